/* rv_settings.svh */
// Global sizing for the memory and write-back stage
// Data path width, data RAM depth and machine CSR addresses

`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// --------------------
// Data path
// --------------------
`define CPU_WIDTH      32

// Word-address bits of the data RAM, 256 words
`define RAM_ADDR_BITS  8

// --------------------
// Machine CSR addresses
// --------------------
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343

`endif

/* rv_isa_pkg.sv */
// RV32I encoding constants used by the write-back stage
// Major opcodes, funct3 codes and the instruction word views

package rv_isa_pkg;

    // --------------------
    // Major opcodes
    // --------------------
    localparam logic [6:0] INST_TYPE_IL  = 7'b0000011;
    localparam logic [6:0] INST_TYPE_S   = 7'b0100011;
    localparam logic [6:0] INST_TYPE_CSR = 7'b1110011;
    localparam logic [6:0] INST_TYPE_I   = 7'b0010011;
    localparam logic [6:0] INST_TYPE_R   = 7'b0110011;

    // --------------------
    // funct3 codes
    // --------------------
    // Loads
    localparam logic [2:0] INST_LB     = 3'b000;
    localparam logic [2:0] INST_LH     = 3'b001;
    localparam logic [2:0] INST_LW     = 3'b010;
    localparam logic [2:0] INST_LBU    = 3'b100;
    localparam logic [2:0] INST_LHU    = 3'b101;
    // Stores
    localparam logic [2:0] INST_SB     = 3'b000;
    localparam logic [2:0] INST_SH     = 3'b001;
    localparam logic [2:0] INST_SW     = 3'b010;
    // CSR access
    localparam logic [2:0] INST_CSRRW  = 3'b001;
    localparam logic [2:0] INST_CSRRS  = 3'b010;
    localparam logic [2:0] INST_CSRRC  = 3'b011;
    localparam logic [2:0] INST_CSRRWI = 3'b101;

    // I-format, also used for loads and CSR instructions
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // S-format, immediate split around rs2
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_fmt_t;

    // Same 32 bits seen through either format
    typedef union packed {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_word_u;

endpackage

/* rv_ctrl_pkg.sv */
// Control types shared between the decoder and the result router
// Result routing selector

package rv_ctrl_pkg;

    // Where the outcome of an instruction goes
    typedef enum logic [1:0] {
        // No architectural effect in this stage
        RESCTRL_NONE = 2'b00,
        // Register write port, loads included
        RESCTRL_REG  = 2'b01,
        // Data memory write, stores
        RESCTRL_MEM  = 2'b10,
        // CSR bank update with old value to rd
        RESCTRL_CSR  = 2'b11
    } res_op_e;

endpackage

/* inst_field_decode.sv */
// Instruction field extraction for the write-back stage
// Immediate selection, routing selector and memory access flag

`include "rv_settings.svh"

module inst_field_decode
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  inst_word_u              inst_i,

    output logic [6:0]              opcode_o,
    output logic [2:0]              funct3_o,
    output logic [`CPU_WIDTH-1:0]   imm_o,
    output logic [4:0]              rd_addr_o,
    output logic [11:0]             csr_addr_o,
    output res_op_e                 res_op_o,
    output logic                    acess_mem_flag_o
);

    // Opcode, funct3 and rd sit at the same place in both views
    assign opcode_o   = inst_i.i_fmt.opcode;
    assign funct3_o   = inst_i.i_fmt.funct3;
    assign rd_addr_o  = inst_i.i_fmt.rd;
    assign csr_addr_o = inst_i.i_fmt.imm;

    // --------------------
    // Immediate
    // --------------------
    always_comb begin
        if (opcode_o == INST_TYPE_S) begin
            imm_o = {{(`CPU_WIDTH-12){inst_i.s_fmt.imm_hi[6]}},
                     inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
        end else if ((opcode_o == INST_TYPE_CSR) && funct3_o[2]) begin
            // uimm lives in the rs1 slot
            imm_o = {{(`CPU_WIDTH-5){1'b0}}, inst_i.i_fmt.rs1};
        end else begin
            imm_o = {{(`CPU_WIDTH-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
        end
    end

    // --------------------
    // Routing
    // --------------------
    always_comb begin
        case (opcode_o)
            INST_TYPE_IL,
            INST_TYPE_I,
            INST_TYPE_R:   res_op_o = RESCTRL_REG;
            INST_TYPE_S:   res_op_o = RESCTRL_MEM;
            // funct3 of zero is ECALL/EBREAK, nothing to route
            INST_TYPE_CSR: res_op_o = (funct3_o != 3'b000) ? RESCTRL_CSR : RESCTRL_NONE;
            default:       res_op_o = RESCTRL_NONE;
        endcase
    end

    assign acess_mem_flag_o = (opcode_o == INST_TYPE_IL) || (opcode_o == INST_TYPE_S);

    // Memory access must be routed to the RAM or to rd through a load
    always_comb begin
        assert final (!acess_mem_flag_o || (res_op_o inside {RESCTRL_MEM, RESCTRL_REG}))
        else $error("memory access flag with routing %s", res_op_o.name());
    end

endmodule

/* alu_res_ctrl.sv */
// Result router of the memory and write-back stage
// Two-cycle load and store sequencing with read-modify-write byte merge
// Load lane extraction and CSR write value selection

`include "rv_settings.svh"

module alu_res_ctrl
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [`CPU_WIDTH-1:0]   rs1_data_i,
    input  logic [`CPU_WIDTH-1:0]   rs2_data_i,
    input  logic [`CPU_WIDTH-1:0]   csr_rd_data_i,
    input  logic [`CPU_WIDTH-1:0]   imm_i,
    input  logic [2:0]              funct3_i,
    input  logic [6:0]              opcode_i,
    input  res_op_e                 alu_res_op_i,
    input  logic [`CPU_WIDTH-1:0]   alu_res_i,
    input  logic [`CPU_WIDTH-1:0]   data_mem_data_i,
    input  logic                    acess_mem_flag_i,

    output logic [`CPU_WIDTH-1:0]   data_mem_addr_o,
    output logic                    data_mem_wr_en_o,
    output logic                    data_mem_req_o,
    output logic [`CPU_WIDTH-1:0]   data_mem_data_o,
    output logic [`CPU_WIDTH-1:0]   reg_wr_data_o,
    output logic                    reg_wr_en_o,
    output logic [`CPU_WIDTH-1:0]   csr_wr_data_o,
    output logic                    csr_wr_en_o,
    output logic                    access_mem_hold_o
);

    logic                   mem_phase;
    logic [1:0]             byte_offset;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [`CPU_WIDTH-1:0]  load_word;
    logic [`CPU_WIDTH-1:0]  store_word;
    logic [`CPU_WIDTH-1:0]  csr_new;

    assign byte_offset = alu_res_i[1:0];

    // --------------------
    // Access phase
    // --------------------
    // Low in the request cycle, high in the data cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_phase <= 1'b0;
        end else if (acess_mem_flag_i) begin
            mem_phase <= ~mem_phase;
        end else begin
            mem_phase <= 1'b0;
        end
    end

    // Stall upstream only during the request cycle
    assign access_mem_hold_o = acess_mem_flag_i && !mem_phase;

    // --------------------
    // Load extension
    // --------------------
    always_comb begin
        case (byte_offset)
            2'b00:   ld_byte = data_mem_data_i[7:0];
            2'b01:   ld_byte = data_mem_data_i[15:8];
            2'b10:   ld_byte = data_mem_data_i[23:16];
            default: ld_byte = data_mem_data_i[31:24];
        endcase
        ld_half = byte_offset[1] ? data_mem_data_i[31:16] : data_mem_data_i[15:0];

        case (funct3_i)
            INST_LB:  load_word = {{24{ld_byte[7]}}, ld_byte};
            INST_LBU: load_word = {24'h0, ld_byte};
            INST_LH:  load_word = {{16{ld_half[15]}}, ld_half};
            INST_LHU: load_word = {16'h0, ld_half};
            default:  load_word = data_mem_data_i;
        endcase
    end

    // --------------------
    // Store merge
    // --------------------
    // Old word from the RAM with only the addressed lane replaced
    always_comb begin
        store_word = data_mem_data_i;
        case (funct3_i)
            INST_SB: store_word[{byte_offset, 3'b000} +: 8] = rs2_data_i[7:0];
            INST_SH: store_word[{byte_offset[1], 4'b0000} +: 16] = rs2_data_i[15:0];
            default: store_word = rs2_data_i;
        endcase
    end

    // CSRRS and CSRRC take the set/clear result from the ALU
    always_comb begin
        case (funct3_i)
            INST_CSRRW:  csr_new = rs1_data_i;
            INST_CSRRWI: csr_new = imm_i;
            default:     csr_new = alu_res_i;
        endcase
    end

    // --------------------
    // Routing
    // --------------------
    always_comb begin
        data_mem_addr_o  = alu_res_i;
        data_mem_req_o   = 1'b0;
        data_mem_wr_en_o = 1'b0;
        data_mem_data_o  = store_word;
        reg_wr_data_o    = '0;
        reg_wr_en_o      = 1'b0;
        csr_wr_data_o    = csr_new;
        csr_wr_en_o      = 1'b0;
        case (alu_res_op_i)
            RESCTRL_MEM: begin
                data_mem_req_o   = 1'b1;
                data_mem_wr_en_o = mem_phase;
            end
            RESCTRL_CSR: begin
                reg_wr_data_o = csr_rd_data_i;
                reg_wr_en_o   = 1'b1;
                csr_wr_en_o   = 1'b1;
            end
            RESCTRL_REG: begin
                if (opcode_i == INST_TYPE_IL) begin
                    data_mem_req_o = 1'b1;
                    reg_wr_data_o  = load_word;
                    reg_wr_en_o    = mem_phase;
                end else begin
                    reg_wr_data_o = alu_res_i;
                    reg_wr_en_o   = 1'b1;
                end
            end
            default: begin
                reg_wr_en_o = 1'b0;
            end
        endcase
    end

    // A stall lasts one cycle per access
    assert property (@(posedge clk) disable iff (!rst_n)
        access_mem_hold_o |=> !access_mem_hold_o)
    else $error("hold asserted in two consecutive cycles");

    // Writes only follow a read request cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        data_mem_wr_en_o |-> data_mem_req_o && $past(access_mem_hold_o))
    else $error("RAM write without preceding read cycle");

endmodule

/* data_ram.sv */
// Word-organised data RAM
// Registered read, whole-word synchronous write

`include "rv_settings.svh"

module data_ram (
    input  logic                    clk,

    input  logic [`CPU_WIDTH-1:0]   addr_i,
    input  logic                    req_i,
    input  logic                    wr_en_i,
    input  logic [`CPU_WIDTH-1:0]   wr_data_i,

    output logic [`CPU_WIDTH-1:0]   rd_data_o
);

    localparam int DEPTH = 2 ** `RAM_ADDR_BITS;

    logic [`CPU_WIDTH-1:0]      mem [DEPTH];
    logic [`RAM_ADDR_BITS-1:0]  word_idx;

    // Byte address, low two bits select a lane outside the RAM
    assign word_idx = addr_i[`RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (req_i) begin
            if (wr_en_i) begin
                mem[word_idx] <= wr_data_i;
            end
            // Old word, so a write cycle still returns valid data
            rd_data_o <= mem[word_idx];
        end
    end

    assert property (@(posedge clk)
        (req_i && wr_en_i) |-> !$isunknown(addr_i))
    else $error("RAM write with unknown address");

endmodule

/* csr_bank.sv */
// Machine CSR bank
// mscratch, mepc, mcause and mtval with combinational read

`include "rv_settings.svh"

module csr_bank (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [11:0]             csr_addr_i,
    input  logic                    csr_wr_en_i,
    input  logic [`CPU_WIDTH-1:0]   csr_wr_data_i,

    output logic [`CPU_WIDTH-1:0]   csr_rd_data_o
);

    logic [`CPU_WIDTH-1:0] mscratch;
    logic [`CPU_WIDTH-1:0] mepc;
    logic [`CPU_WIDTH-1:0] mcause;
    logic [`CPU_WIDTH-1:0] mtval;

    // Unimplemented addresses read as zero
    always_comb begin
        case (csr_addr_i)
            `CSR_MSCRATCH: csr_rd_data_o = mscratch;
            `CSR_MEPC:     csr_rd_data_o = mepc;
            `CSR_MCAUSE:   csr_rd_data_o = mcause;
            `CSR_MTVAL:    csr_rd_data_o = mtval;
            default:       csr_rd_data_o = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (csr_wr_en_i) begin
            case (csr_addr_i)
                `CSR_MSCRATCH: mscratch <= csr_wr_data_i;
                `CSR_MEPC:     mepc     <= csr_wr_data_i;
                `CSR_MCAUSE:   mcause   <= csr_wr_data_i;
                `CSR_MTVAL:    mtval    <= csr_wr_data_i;
                // Writes to other addresses are dropped
                default: ;
            endcase
        end
    end

endmodule

/* mem_wb_top.sv */
// Memory and write-back stage top level
// Decoder, result router, data RAM and CSR bank

`include "rv_settings.svh"

module mem_wb_top
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  inst_word_u              inst_i,
    input  logic [`CPU_WIDTH-1:0]   rs1_data_i,
    input  logic [`CPU_WIDTH-1:0]   rs2_data_i,
    input  logic [`CPU_WIDTH-1:0]   alu_res_i,

    output logic [`CPU_WIDTH-1:0]   reg_wr_data_o,
    output logic                    reg_wr_en_o,
    output logic [4:0]              rd_addr_o,
    output logic                    access_mem_hold_o
);

    // Decoder outputs
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [`CPU_WIDTH-1:0]  imm;
    logic [11:0]            csr_addr;
    res_op_e                res_op;
    logic                   acess_mem_flag;

    // --------------------
    // RAM and CSR side
    // --------------------
    logic [`CPU_WIDTH-1:0]  mem_addr;
    logic                   mem_req;
    logic                   mem_wr_en;
    logic [`CPU_WIDTH-1:0]  mem_wr_data;
    logic [`CPU_WIDTH-1:0]  mem_rd_data;
    logic [`CPU_WIDTH-1:0]  csr_rd_data;
    logic [`CPU_WIDTH-1:0]  csr_wr_data;
    logic                   csr_wr_en;

    inst_field_decode u_decode (
        .inst_i           (inst_i),
        .opcode_o         (opcode),
        .funct3_o         (funct3),
        .imm_o            (imm),
        .rd_addr_o        (rd_addr_o),
        .csr_addr_o       (csr_addr),
        .res_op_o         (res_op),
        .acess_mem_flag_o (acess_mem_flag)
    );

    alu_res_ctrl u_res_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .rs1_data_i        (rs1_data_i),
        .rs2_data_i        (rs2_data_i),
        .csr_rd_data_i     (csr_rd_data),
        .imm_i             (imm),
        .funct3_i          (funct3),
        .opcode_i          (opcode),
        .alu_res_op_i      (res_op),
        .alu_res_i         (alu_res_i),
        .data_mem_data_i   (mem_rd_data),
        .acess_mem_flag_i  (acess_mem_flag),
        .data_mem_addr_o   (mem_addr),
        .data_mem_wr_en_o  (mem_wr_en),
        .data_mem_req_o    (mem_req),
        .data_mem_data_o   (mem_wr_data),
        .reg_wr_data_o     (reg_wr_data_o),
        .reg_wr_en_o       (reg_wr_en_o),
        .csr_wr_data_o     (csr_wr_data),
        .csr_wr_en_o       (csr_wr_en),
        .access_mem_hold_o (access_mem_hold_o)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .addr_i    (mem_addr),
        .req_i     (mem_req),
        .wr_en_i   (mem_wr_en),
        .wr_data_i (mem_wr_data),
        .rd_data_o (mem_rd_data)
    );

    csr_bank u_csr_bank (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_addr_i    (csr_addr),
        .csr_wr_en_i   (csr_wr_en),
        .csr_wr_data_i (csr_wr_data),
        .csr_rd_data_o (csr_rd_data)
    );

endmodule

/* tb_checker.sv */
// Result checker for the memory and write-back stage
// Samples DUT outputs at the closing rising edge of each test
// Compares write port, rd address and hold length, prints one line per test

module tb_checker (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         check_i,
    input  logic [127:0] exp_name_i,
    input  logic         exp_en_i,
    input  logic [4:0]   exp_rd_i,
    input  logic [31:0]  exp_data_i,
    input  logic         exp_mem_i,
    input  logic [31:0]  reg_wr_data_i,
    input  logic         reg_wr_en_i,
    input  logic [4:0]   rd_addr_i,
    input  logic         hold_i,
    output int           pass_cnt_o,
    output int           fail_cnt_o,
    output int           checked_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int pass_cnt = 0;
    int fail_cnt = 0;
    int checked = 0;
    // Rising edges with hold high since the last check
    int hold_cnt = 0;
    int hold_seen;

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;
    assign checked_o  = checked;

    task automatic grade_entry();
        bit ok;
        ok = 1'b1;
        checked++;
        // Data only matters when the port is written
        if ((reg_wr_en_i !== exp_en_i) || (exp_en_i && (reg_wr_data_i !== exp_data_i))) begin
            $display("FAIL %0s: expected en=%0b data=%08h, actual en=%0b data=%08h",
                     exp_name_i, exp_en_i, exp_data_i, reg_wr_en_i, reg_wr_data_i);
            ok = 1'b0;
        end
        if (exp_en_i && (rd_addr_i !== exp_rd_i)) begin
            $display("FAIL %0s: expected rd=%0d, actual rd=%0d",
                     exp_name_i, exp_rd_i, rd_addr_i);
            ok = 1'b0;
        end
        if (exp_mem_i && (hold_seen != 1)) begin
            $display("FAIL %0s: hold lasted %0d cycles instead of exactly one",
                     exp_name_i, hold_seen);
            ok = 1'b0;
        end else if (!exp_mem_i && (hold_seen != 0)) begin
            $display("FAIL %0s: hold was raised on an instruction without memory access",
                     exp_name_i);
            ok = 1'b0;
        end
        if (ok) begin
            $display("PASS %0s", exp_name_i);
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
    endtask

    // Values read here are the ones held since the previous falling edge
    always @(posedge clk) begin
        if (!rst_n) begin
            hold_cnt = 0;
            if (hold_i || reg_wr_en_i) begin
                $display("Error: hold or register write active while in reset");
                fail_cnt++;
            end
        end else begin
            hold_seen = hold_i ? hold_cnt + 1 : hold_cnt;
            if (check_i) begin
                grade_entry();
                hold_cnt = 0;
            end else begin
                hold_cnt = hold_seen;
            end
        end
    end

endmodule

/* tb_top.sv */
// Testbench top for the memory and write-back stage
// Clock, reset, stimulus table, DUT instance and watchdog

`include "rv_settings.svh"

module tb_top
    import rv_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    // One row of the stimulus table
    typedef struct packed {
        logic [127:0]           name;
        logic [`CPU_WIDTH-1:0]  inst;
        logic [`CPU_WIDTH-1:0]  rs1;
        logic [`CPU_WIDTH-1:0]  rs2;
        logic [`CPU_WIDTH-1:0]  alu_res;
        logic                   exp_en;
        logic [4:0]             exp_rd;
        logic [`CPU_WIDTH-1:0]  exp_data;
    } entry_t;

    entry_t tests [$];
    bit     table_ready = 1'b0;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic [`CPU_WIDTH-1:0]  inst = '0;
    logic [`CPU_WIDTH-1:0]  rs1_data = '0;
    logic [`CPU_WIDTH-1:0]  rs2_data = '0;
    logic [`CPU_WIDTH-1:0]  alu_res = '0;
    logic [`CPU_WIDTH-1:0]  reg_wr_data;
    logic                   reg_wr_en;
    logic [4:0]             rd_addr;
    logic                   hold;

    // Expected values handed to the checker
    logic [127:0]           exp_name = '0;
    logic                   exp_en = 1'b0;
    logic [4:0]             exp_rd = '0;
    logic [`CPU_WIDTH-1:0]  exp_data = '0;
    logic                   exp_mem = 1'b0;
    logic                   check = 1'b0;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     checked;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Instruction encoding
    // --------------------
    function automatic logic [31:0] i_format(input logic [6:0] op, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_format(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], INST_TYPE_S};
    endfunction

    function automatic logic [31:0] r_format(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, f3, rd, INST_TYPE_R};
    endfunction

    function automatic bit touches_memory(input logic [31:0] word);
        return (word[6:0] == INST_TYPE_IL) || (word[6:0] == INST_TYPE_S);
    endfunction

    // --------------------
    // Table building
    // --------------------
    task automatic push_entry(input logic [127:0] name, input logic [31:0] word,
                              input logic [31:0] rs1, input logic [31:0] rs2,
                              input logic [31:0] alu, input logic en, input logic [4:0] rd,
                              input logic [31:0] data);
        entry_t e;
        e.name     = name;
        e.inst     = word;
        e.rs1      = rs1;
        e.rs2      = rs2;
        e.alu_res  = alu;
        e.exp_en   = en;
        e.exp_rd   = rd;
        e.exp_data = data;
        tests.push_back(e);
    endtask

    // Plain ALU ops pass alu_res straight to rd
    task automatic reg_entry(input logic [127:0] name, input logic [4:0] rd,
                             input logic [31:0] word, input logic [31:0] value);
        push_entry(name, word, ~value, value ^ 32'h5a5a_5a5a, value, 1'b1, rd, value);
    endtask

    task automatic load_entry(input logic [127:0] name, input logic [2:0] f3,
                              input logic [31:0] addr, input logic [31:0] value);
        push_entry(name, i_format(INST_TYPE_IL, f3, 5'd3, 5'd2, 12'h000), 32'h0, 32'h0,
                   addr, 1'b1, 5'd3, value);
    endtask

    task automatic store_entry(input logic [127:0] name, input logic [2:0] f3,
                               input logic [31:0] addr, input logic [31:0] data);
        push_entry(name, s_format(f3, 5'd2, 5'd4, 12'h000), 32'h0, data, addr, 1'b0, 5'd0,
                   32'h0);
    endtask

    // Old CSR value is expected on rd
    task automatic csr_entry(input logic [127:0] name, input logic [2:0] f3,
                             input logic [11:0] csr, input logic [4:0] src,
                             input logic [31:0] rs1, input logic [31:0] alu,
                             input logic [31:0] old_value);
        push_entry(name, i_format(INST_TYPE_CSR, f3, 5'd7, src, csr), rs1, 32'h0, alu,
                   1'b1, 5'd7, old_value);
    endtask

    task automatic fill_table();
        logic [31:0] rnd [3];
        foreach (rnd[k]) rnd[k] = $urandom();
        push_entry("reset_idle", 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
        reg_entry("reg_addi", 5'd5, i_format(INST_TYPE_I, 3'b000, 5'd5, 5'd1, 12'h005),
                  rnd[0]);
        reg_entry("reg_add", 5'd6, r_format(3'b000, 5'd6, 5'd1, 5'd2), rnd[1]);
        reg_entry("reg_xori", 5'd8, i_format(INST_TYPE_I, 3'b100, 5'd8, 5'd1, 12'hfff),
                  rnd[2]);
        // Whole word round trip
        store_entry("sw_word", INST_SW, 32'h10, 32'hdead_beef);
        load_entry("lw_word", INST_LW, 32'h10, 32'hdead_beef);
        // Byte lanes over 11223344
        store_entry("sw_base_b", INST_SW, 32'h20, 32'h1122_3344);
        store_entry("sb_off0", INST_SB, 32'h20, 32'hffff_ffa5);
        load_entry("lw_sb_off0", INST_LW, 32'h20, 32'h1122_33a5);
        store_entry("sb_off1", INST_SB, 32'h21, 32'h0000_00b6);
        store_entry("sb_off2", INST_SB, 32'h22, 32'h1234_56c7);
        store_entry("sb_off3", INST_SB, 32'h23, 32'h0000_00d8);
        load_entry("lw_merged_b", INST_LW, 32'h20, 32'hd8c7_b6a5);
        // Halfword lanes over 55667788
        store_entry("sw_base_h", INST_SW, 32'h24, 32'h5566_7788);
        store_entry("sh_off0", INST_SH, 32'h24, 32'hffff_1234);
        store_entry("sh_off2", INST_SH, 32'h26, 32'h0000_abcd);
        load_entry("lw_merged_h", INST_LW, 32'h24, 32'habcd_1234);
        // Extension over 80017ffe
        store_entry("sw_ext", INST_SW, 32'h30, 32'h8001_7ffe);
        load_entry("lb_off0", INST_LB, 32'h30, 32'hffff_fffe);
        load_entry("lb_off1", INST_LB, 32'h31, 32'h0000_007f);
        load_entry("lb_off2", INST_LB, 32'h32, 32'h0000_0001);
        load_entry("lb_off3", INST_LB, 32'h33, 32'hffff_ff80);
        load_entry("lbu_off0", INST_LBU, 32'h30, 32'h0000_00fe);
        load_entry("lbu_off1", INST_LBU, 32'h31, 32'h0000_007f);
        load_entry("lbu_off2", INST_LBU, 32'h32, 32'h0000_0001);
        load_entry("lbu_off3", INST_LBU, 32'h33, 32'h0000_0080);
        load_entry("lh_off0", INST_LH, 32'h30, 32'h0000_7ffe);
        load_entry("lh_off2", INST_LH, 32'h32, 32'hffff_8001);
        load_entry("lhu_off0", INST_LHU, 32'h30, 32'h0000_7ffe);
        load_entry("lhu_off2", INST_LHU, 32'h32, 32'h0000_8001);
        // CSR accesses
        csr_entry("csrrw_msc_a", INST_CSRRW, `CSR_MSCRATCH, 5'd1, 32'h1234_5678, 32'h0, 32'h0);
        csr_entry("csrrw_msc_b", INST_CSRRW, `CSR_MSCRATCH, 5'd1, 32'hcafe_f00d, 32'h0,
                  32'h1234_5678);
        csr_entry("csrrwi_mepc", INST_CSRRWI, `CSR_MEPC, 5'd19, 32'hffff_ffff, 32'h0, 32'h0);
        csr_entry("csrrs_mcause", INST_CSRRS, `CSR_MCAUSE, 5'd1, 32'h0, 32'h0000_00f0, 32'h0);
        csr_entry("csrr_mepc", INST_CSRRS, `CSR_MEPC, 5'd0, 32'h0, 32'd19, 32'd19);
        csr_entry("csrr_mcause", INST_CSRRS, `CSR_MCAUSE, 5'd0, 32'h0, 32'h0000_00f0,
                  32'h0000_00f0);
        csr_entry("csrr_mscratch", INST_CSRRS, `CSR_MSCRATCH, 5'd0, 32'h0, 32'hcafe_f00d,
                  32'hcafe_f00d);
        csr_entry("csrrw_unknown", INST_CSRRW, 12'h7c0, 5'd1, 32'hffff_ffff, 32'h0, 32'h0);
        csr_entry("csrr_unknown", INST_CSRRS, 12'h7c0, 5'd0, 32'h0, 32'h0, 32'h0);
    endtask

    // Drive one row, memory rows get a second cycle before the check
    task automatic apply_entry(input entry_t e);
        bit mem;
        mem = touches_memory(e.inst);
        @(negedge clk);
        inst     = e.inst;
        rs1_data = e.rs1;
        rs2_data = e.rs2;
        alu_res  = e.alu_res;
        exp_name = e.name;
        exp_en   = e.exp_en;
        exp_rd   = e.exp_rd;
        exp_data = e.exp_data;
        exp_mem  = mem;
        check    = !mem;
        if (mem) begin
            @(negedge clk);
            check = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'h4cf8635e));
        fill_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        foreach (tests[i]) apply_entry(tests[i]);
        @(negedge clk);
        check = 1'b0;
        wait (checked == tests.size());
        $display("Tests run %0d, passed %0d, failed %0d", checked, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Four cycles per row is well above the two a memory row takes
    initial begin
        wait (table_ready);
        repeat (tests.size() * 4 + 100) @(posedge clk);
        $display("Watchdog expired before the stimulus table completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    mem_wb_top dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_i            (inst),
        .rs1_data_i        (rs1_data),
        .rs2_data_i        (rs2_data),
        .alu_res_i         (alu_res),
        .reg_wr_data_o     (reg_wr_data),
        .reg_wr_en_o       (reg_wr_en),
        .rd_addr_o         (rd_addr),
        .access_mem_hold_o (hold)
    );

    tb_checker u_check (
        .clk           (clk),
        .rst_n         (rst_n),
        .check_i       (check),
        .exp_name_i    (exp_name),
        .exp_en_i      (exp_en),
        .exp_rd_i      (exp_rd),
        .exp_data_i    (exp_data),
        .exp_mem_i     (exp_mem),
        .reg_wr_data_i (reg_wr_data),
        .reg_wr_en_i   (reg_wr_en),
        .rd_addr_i     (rd_addr),
        .hold_i        (hold),
        .pass_cnt_o    (pass_cnt),
        .fail_cnt_o    (fail_cnt),
        .checked_o     (checked)
    );

endmodule

/* vlog.f */
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
inst_field_decode.sv
alu_res_ctrl.sv
data_ram.sv
csr_bank.sv
mem_wb_top.sv
tb_checker.sv
tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory and write-back stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module tb_top -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Run passed"
    exit 0
fi
echo "Run failed, see sim.log"
exit 1
